// File: dv/trace_recorder_chk.sv
// Trace recorder port checker
// Reset values, last/valid pairing, CSR line order,
// nonzero REG index and sticky overflow

`timescale 1ns/100ps
`include "trace_settings.svh"

module trace_recorder_chk (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         line_valid_o,
    input  logic                         line_last_o,
    input  trace_pkg::line_kind_e        line_kind_o,
    input  logic [`TRACE_REG_AW-1:0]     line_reg_o,
    input  logic                         overflow_o
);
    import trace_pkg::*;

    // ----------------------------------------------------------
    // Reset behavior
    // ----------------------------------------------------------
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!line_valid_o && !line_last_o && !overflow_o))
        else $error("line outputs or overflow not low after a reset edge");

    // ----------------------------------------------------------
    // Line framing
    // ----------------------------------------------------------
    a_last_has_valid: assert property (@(posedge clk) disable iff (!rst_n)
        line_last_o |-> line_valid_o)
        else $error("line_last_o high without line_valid_o");

    // Exception and interrupt records keep their four lines together
    a_csr_order: assert property (@(posedge clk) disable iff (!rst_n)
        (line_valid_o && line_kind_o == LINE_MSTATUS)
        |=> (line_valid_o && line_kind_o == LINE_MEPC)
        ##1 (line_valid_o && line_kind_o == LINE_MCAUSE)
        ##1 (line_valid_o && line_kind_o == LINE_MTVAL))
        else $error("MSTATUS line not followed by MEPC, MCAUSE, MTVAL");

    a_reg_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        (line_valid_o && line_kind_o == LINE_REG) |-> (line_reg_o != '0))
        else $error("REG line with register index 0");

    // Sticky until reset
    a_overflow_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $past(overflow_o) |-> overflow_o)
        else $error("overflow_o fell while out of reset");

endmodule

bind trace_recorder trace_recorder_chk u_chk (.*);

// File: dv/trace_recorder_tb.sv
// Trace recorder testbench
// Clock, reset and retire-side stimulus
// Expected-line model built from the line expansion rules
// Burst check for overflow

`timescale 1ns/100ps
`include "trace_settings.svh"

module trace_recorder_tb;
    import trace_pkg::*;

    typedef struct packed {
        line_kind_e                 kind;
        trace_event_e               ev;
        logic [`TRACE_XLEN-1:0]     pc, npc, instr;
        logic [`TRACE_REG_AW-1:0]   rg;
        logic [`TRACE_XLEN-1:0]     value;
        logic                       last;
    } exp_line_t;

    logic clk, rst_n;
    logic pc_update_i, reg_wr_i, exc_i, irq_i, wake_i;
    logic [`TRACE_XLEN-1:0] next_pc_i, instr_i, reg_data_i, mtval_i;
    logic [`TRACE_REG_AW-1:0] reg_addr_i;
    logic mstatus_mie_i, mstatus_mpie_i, mie_msie_i, mie_mtie_i, mie_meie_i;
    logic mip_msip_i, mip_mtip_i, mip_meip_i, mcause_irq_i;
    logic [`TRACE_XLEN-2:0] mepc_i;
    logic [`TRACE_EC_W-1:0] mcause_ec_i;
    logic line_valid_o, line_last_o, overflow_o;
    trace_event_e line_event_o;
    line_kind_e line_kind_o;
    logic [`TRACE_TIME_W-1:0] line_time_o;
    logic [`TRACE_XLEN-1:0] line_pc_o, line_instr_o, line_npc_o, line_value_o;
    logic [`TRACE_REG_AW-1:0] line_reg_o;

    exp_line_t exp_q[$];
    string test_name;
    logic [`TRACE_XLEN-1:0] prev_npc;       // Model of the PC chain
    logic [`TRACE_TIME_W-1:0] last_time;
    logic have_time, rec_start, burst_mode;
    int burst_idx;
    int burst_recs;                         // Whole records seen in the burst

    trace_recorder u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string field, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %s %s: expected %h, actual %h", test_name, field, exp, act);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic abort_test(input string msg);
        $display("%s during %s", msg, test_name);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string field, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else report_mismatch(field, exp, act);
    endtask

    // ----------------------------------------------------------
    // Line monitor, samples away from the driving edge
    // ----------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && line_valid_o) begin
            if (rec_start) begin   // Time stamps rise record by record
                assert (!have_time || line_time_o > last_time)
                    else abort_test("time stamp did not increase");
                last_time = line_time_o;
                have_time = 1'b1;
            end
            if (burst_mode) begin
                check_val("kind", 32'(burst_idx + 2), 32'(line_kind_o));
                check_val("event", 32'(EV_EXC), 32'(line_event_o));
                check_val("last", 32'(burst_idx == 3), 32'(line_last_o));
                burst_idx = (burst_idx + 1) % 4;
                if (line_last_o) burst_recs++;
            end else begin
                exp_line_t e;
                assert (exp_q.size() != 0) else abort_test("unexpected trace line");
                e = exp_q.pop_front();
                check_val("kind", 32'(e.kind), 32'(line_kind_o));
                check_val("event", 32'(e.ev), 32'(line_event_o));
                check_val("pc", e.pc, line_pc_o);
                check_val("npc", e.npc, line_npc_o);
                check_val("instr", e.instr, line_instr_o);
                check_val("reg", 32'(e.rg), 32'(line_reg_o));
                check_val("value", e.value, line_value_o);
                check_val("last", 32'(e.last), 32'(line_last_o));
            end
            rec_start = line_last_o;
        end
    end

    // CSR images from the field layout
    function automatic logic [31:0] irq_bits_image(input logic a, input logic b, input logic c);
        return (32'(a) << `TRACE_MSIE_BIT) | (32'(b) << `TRACE_MTIE_BIT)
             | (32'(c) << `TRACE_MEIE_BIT);
    endfunction

    // One update with its expected lines
    task automatic update(input logic pcu, input logic wr, input logic [4:0] addr,
                          input logic exc, input logic irq, input logic wake);
        exp_line_t e;
        logic [31:0] npc, ins, data, mip_img, mie_img, mst_img, mcause_img;
        npc  = $urandom & 32'hffff_fffe;
        ins  = $urandom;
        data = $urandom;
        @(posedge clk);
        pc_update_i <= pcu;
        reg_wr_i    <= wr;
        reg_addr_i  <= addr;
        reg_data_i  <= data;
        next_pc_i   <= npc;
        instr_i     <= ins;
        exc_i <= exc;
        irq_i <= irq;
        wake_i <= wake;
        @(posedge clk);
        pc_update_i <= 1'b0;
        reg_wr_i    <= 1'b0;
        exc_i <= 1'b0;
        irq_i <= 1'b0;
        wake_i <= 1'b0;
        mip_img = irq_bits_image(mip_msip_i, mip_mtip_i, mip_meip_i);
        mie_img = irq_bits_image(mie_msie_i, mie_mtie_i, mie_meie_i);
        mst_img = (32'(mstatus_mie_i) << `TRACE_MSTATUS_MIE_BIT)
                | (32'(mstatus_mpie_i) << `TRACE_MSTATUS_MPIE_BIT)
                | (32'b11 << `TRACE_MSTATUS_MPP_LSB);      // MPP machine
        mcause_img = (32'(mcause_irq_i) << 31) | 32'(mcause_ec_i);   // Flag on top
        e = '0;
        e.pc = prev_npc;
        e.npc = npc;
        e.instr = ins;
        e.ev = exc ? EV_EXC : irq ? EV_IRQ : wake ? EV_WAKE : EV_NONE;
        prev_npc = npc;
        if (exc || irq) begin
            e.kind = LINE_MSTATUS;
            e.value = mst_img;
            exp_q.push_back(e);
            e.kind = LINE_MEPC;
            e.value = 32'(mepc_i) << 1;     // Zero low bit
            exp_q.push_back(e);
            e.kind = LINE_MCAUSE;
            e.value = mcause_img;
            exp_q.push_back(e);
            e.kind = LINE_MTVAL;
            e.value = mtval_i;
            e.last = 1'b1;
            exp_q.push_back(e);
        end else if (wake && (mip_img & mie_img) != 0) begin
            e.kind = LINE_MIP;
            e.value = mip_img;
            exp_q.push_back(e);
            e.kind = LINE_MIE;
            e.value = mie_img;
            e.last = 1'b1;
            exp_q.push_back(e);
        end else begin
            e.last = 1'b1;
            if (!wake && wr && addr != 0) begin
                e.kind = LINE_REG;
                e.rg = addr;
                e.value = data;
            end else begin
                e.kind = LINE_EMPTY;
            end
            exp_q.push_back(e);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || line_valid_o) && n < 300) begin
            @(negedge clk);
            n++;
        end
        if (n >= 300) abort_test("Timeout waiting for expected trace lines");
    endtask

    initial begin
        void'($urandom(32'h9c71_4852));
        {pc_update_i, reg_wr_i, exc_i, irq_i, wake_i} <= '0;
        {next_pc_i, instr_i, reg_data_i, mtval_i, mepc_i} <= '0;
        reg_addr_i <= '0;
        {mstatus_mie_i, mstatus_mpie_i, mie_msie_i, mie_mtie_i, mie_meie_i} <= '0;
        {mip_msip_i, mip_mtip_i, mip_meip_i, mcause_irq_i} <= '0;
        mcause_ec_i <= '0;
        {have_time, burst_mode} = '0;
        rec_start = 1'b1;
        burst_idx = 0;
        burst_recs = 0;
        prev_npc = '0;
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "idle";                      // Any line here is unexpected
        repeat (20) @(posedge clk);

        test_name = "reg_write";
        for (int i = 0; i < 16; i++) begin
            update(i % 5 != 4, i % 5 != 3, (i % 4 == 0) ? 5'd0 : 5'($urandom_range(1, 31)),
                   1'b0, 1'b0, 1'b0);
        end
        wait_drain();

        test_name = "exception";
        @(posedge clk);
        mstatus_mie_i <= 1'b1;
        mstatus_mpie_i <= 1'b0;
        mepc_i <= 31'($urandom);
        mcause_ec_i <= 4'd2;
        mtval_i <= $urandom;
        update(1'b1, 1'b0, 5'd0, 1'b1, 1'b1, 1'b0);
        wait_drain();
        test_name = "interrupt";
        @(posedge clk);
        mstatus_mpie_i <= 1'b1;
        mcause_irq_i <= 1'b1;
        mcause_ec_i <= 4'd11;
        update(1'b1, 1'b0, 5'd0, 1'b0, 1'b1, 1'b0);
        wait_drain();

        test_name = "wake_pending";
        @(posedge clk);
        mip_mtip_i <= 1'b1;
        mie_mtie_i <= 1'b1;
        mie_msie_i <= 1'b1;
        update(1'b1, 1'b0, 5'd0, 1'b0, 1'b0, 1'b1);
        wait_drain();
        test_name = "wake_none";
        @(posedge clk);
        mie_mtie_i <= 1'b0;
        update(1'b1, 1'b0, 5'd0, 1'b0, 1'b0, 1'b1);
        wait_drain();

        // ----------------------------------------------------------
        // Back-to-back exceptions, more than the queue holds
        // ----------------------------------------------------------
        test_name = "overflow_burst";
        check_val("overflow", 32'd0, 32'(overflow_o));   // Spaced updates fit the queue
        burst_mode = 1'b1;
        for (int i = 0; i < 12; i++) begin
            @(posedge clk);
            pc_update_i <= 1'b1;
            exc_i <= 1'b1;
            next_pc_i <= $urandom;
        end
        @(posedge clk);
        pc_update_i <= 1'b0;
        exc_i <= 1'b0;
        @(negedge clk);
        begin
            int n;
            n = 0;
            while (!line_valid_o && n < 50) begin
                @(negedge clk);
                n++;
            end
            if (n >= 50) abort_test("Timeout waiting for the first burst line");
            n = 0;
            while (line_valid_o && n < 200) begin
                @(negedge clk);
                n++;
            end
            if (n >= 200) abort_test("Timeout waiting for the burst to drain");
        end
        check_val("burst_idx", 32'd0, 32'(burst_idx));   // Only whole records
        // One expanding plus a full queue must always come out
        assert (burst_recs >= `TRACE_QUEUE_DEPTH + 1)
            else abort_test("burst emitted fewer records than the queue holds");
        repeat (10) @(negedge clk);
        check_val("overflow", 32'd1, 32'(overflow_o));

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: hw/trace_capture.sv
// Trace capture stage
// Free-running cycle counter
// Update detection and event classification
// Record registers with PC chaining and CSR snapshot

`timescale 1ns/100ps
`include "trace_settings.svh"

module trace_capture (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pc_update_i,     // PC update strobe
    input  logic [`TRACE_XLEN-1:0]       next_pc_i,
    input  logic [`TRACE_XLEN-1:0]       instr_i,
    input  logic                         reg_wr_i,        // Register-file write strobe
    input  logic [`TRACE_REG_AW-1:0]     reg_addr_i,
    input  logic [`TRACE_XLEN-1:0]       reg_data_i,
    input  logic                         exc_i,
    input  logic                         irq_i,
    input  logic                         wake_i,
    input  logic [`TRACE_XLEN-1:0]       mstatus_i,
    input  logic [`TRACE_XLEN-1:0]       mepc_i,
    input  logic [`TRACE_XLEN-1:0]       mcause_i,
    input  logic [`TRACE_XLEN-1:0]       mtval_i,
    input  logic [`TRACE_XLEN-1:0]       mip_i,
    input  logic [`TRACE_XLEN-1:0]       mie_i,
    output logic                         rec_valid_o,     // One-cycle pulse per record
    output trace_pkg::trace_event_e      rec_event_o,
    output logic [`TRACE_TIME_W-1:0]     rec_time_o,
    output logic [`TRACE_XLEN-1:0]       rec_pc_o,
    output logic [`TRACE_XLEN-1:0]       rec_instr_o,
    output logic [`TRACE_XLEN-1:0]       rec_npc_o,
    output logic                         rec_reg_wr_o,
    output logic [`TRACE_REG_AW-1:0]     rec_reg_addr_o,
    output logic [`TRACE_XLEN-1:0]       rec_reg_data_o,
    output logic [`TRACE_XLEN-1:0]       rec_mstatus_o,
    output logic [`TRACE_XLEN-1:0]       rec_mepc_o,
    output logic [`TRACE_XLEN-1:0]       rec_mcause_o,
    output logic [`TRACE_XLEN-1:0]       rec_mtval_o,
    output logic [`TRACE_XLEN-1:0]       rec_mip_o,
    output logic [`TRACE_XLEN-1:0]       rec_mie_o
);
    import trace_pkg::*;

    logic [`TRACE_TIME_W-1:0]   cycle_cnt;     // Cycles since reset release
    logic                       update;        // Trace update seen this edge
    trace_event_e               event_nxt;

    assign update = pc_update_i | reg_wr_i;

    // Event class by priority
    always_comb begin
        if (exc_i)        event_nxt = EV_EXC;
        else if (irq_i)   event_nxt = EV_IRQ;
        else if (wake_i)  event_nxt = EV_WAKE;
        else              event_nxt = EV_NONE;
    end

    // ----------------------------------------------------------
    // Cycle counter, 0 at first edge after reset
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Record control and PC chain
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rec_valid_o  <= 1'b0;
            rec_event_o  <= EV_NONE;
            rec_time_o   <= '0;
            rec_pc_o     <= '0;
            rec_npc_o    <= '0;
            rec_reg_wr_o <= 1'b0;
        end else begin
            rec_valid_o <= update;
            if (update) begin
                rec_event_o  <= event_nxt;
                rec_time_o   <= cycle_cnt;            // Count sampled at this edge
                rec_pc_o     <= rec_npc_o;            // Current PC from last next PC
                rec_npc_o    <= next_pc_i;
                rec_reg_wr_o <= reg_wr_i && (reg_addr_i != '0);   // x0 never reported
            end
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (update) begin
            rec_instr_o   <= instr_i;
            rec_mstatus_o <= mstatus_i;   // CSR snapshot
            rec_mepc_o    <= mepc_i;
            rec_mcause_o  <= mcause_i;
            rec_mtval_o   <= mtval_i;
            rec_mip_o     <= mip_i;
            rec_mie_o     <= mie_i;
        end
        if (reg_wr_i) begin
            rec_reg_addr_o <= reg_addr_i;
            rec_reg_data_o <= reg_data_i;
        end
    end

endmodule

// File: hw/trace_csr_pack.sv
// Machine CSR image assembly
// Builds mstatus, mie, mip, mepc, mcause and mtval from loose fields
// Purely combinational

`timescale 1ns/100ps
`include "trace_settings.svh"

module trace_csr_pack (
    input  logic                     mstatus_mie_i,
    input  logic                     mstatus_mpie_i,
    input  logic                     mie_msie_i,
    input  logic                     mie_mtie_i,
    input  logic                     mie_meie_i,
    input  logic                     mip_msip_i,
    input  logic                     mip_mtip_i,
    input  logic                     mip_meip_i,
    input  logic [`TRACE_XLEN-2:0]   mepc_i,        // Bits 31..1, RVC alignment
    input  logic                     mcause_irq_i,
    input  logic [`TRACE_EC_W-1:0]   mcause_ec_i,
    input  logic [`TRACE_XLEN-1:0]   mtval_i,
    output logic [`TRACE_XLEN-1:0]   mstatus_o,
    output logic [`TRACE_XLEN-1:0]   mie_o,
    output logic [`TRACE_XLEN-1:0]   mip_o,
    output logic [`TRACE_XLEN-1:0]   mepc_o,
    output logic [`TRACE_XLEN-1:0]   mcause_o,
    output logic [`TRACE_XLEN-1:0]   mtval_o
);

    // ----------------------------------------------------------
    // Bit-field images
    // ----------------------------------------------------------
    always_comb begin
        mstatus_o = '0;
        mstatus_o[`TRACE_MSTATUS_MIE_BIT]  = mstatus_mie_i;
        mstatus_o[`TRACE_MSTATUS_MPIE_BIT] = mstatus_mpie_i;
        mstatus_o[`TRACE_MSTATUS_MPP_LSB +: 2] = `TRACE_MPP_MACHINE;   // MPP always M

        mie_o = '0;
        mie_o[`TRACE_MSIE_BIT] = mie_msie_i;
        mie_o[`TRACE_MTIE_BIT] = mie_mtie_i;
        mie_o[`TRACE_MEIE_BIT] = mie_meie_i;

        // Same layout as mie
        mip_o = '0;
        mip_o[`TRACE_MSIE_BIT] = mip_msip_i;
        mip_o[`TRACE_MTIE_BIT] = mip_mtip_i;
        mip_o[`TRACE_MEIE_BIT] = mip_meip_i;
    end

    // ----------------------------------------------------------
    // Whole-word images
    // ----------------------------------------------------------
    assign mepc_o   = {mepc_i, 1'b0};   // Bit 0 never stored
    assign mcause_o = {mcause_irq_i, {(`TRACE_XLEN-1-`TRACE_EC_W){1'b0}}, mcause_ec_i};
    assign mtval_o  = mtval_i;

endmodule

// File: hw/trace_line_seq.sv
// Trace line sequencer
// Record queue with sticky overflow flag
// Line-expansion FSM, one line per cycle
// Line field and value selection

`timescale 1ns/100ps
`include "trace_settings.svh"

module trace_line_seq (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rec_valid_i,
    input  trace_pkg::trace_event_e      rec_event_i,
    input  logic [`TRACE_TIME_W-1:0]     rec_time_i,
    input  logic [`TRACE_XLEN-1:0]       rec_pc_i,
    input  logic [`TRACE_XLEN-1:0]       rec_instr_i,
    input  logic [`TRACE_XLEN-1:0]       rec_npc_i,
    input  logic                         rec_reg_wr_i,
    input  logic [`TRACE_REG_AW-1:0]     rec_reg_addr_i,
    input  logic [`TRACE_XLEN-1:0]       rec_reg_data_i,
    input  logic [`TRACE_XLEN-1:0]       rec_mstatus_i,
    input  logic [`TRACE_XLEN-1:0]       rec_mepc_i,
    input  logic [`TRACE_XLEN-1:0]       rec_mcause_i,
    input  logic [`TRACE_XLEN-1:0]       rec_mtval_i,
    input  logic [`TRACE_XLEN-1:0]       rec_mip_i,
    input  logic [`TRACE_XLEN-1:0]       rec_mie_i,
    output logic                         line_valid_o,
    output logic                         line_last_o,     // Final line of a record
    output trace_pkg::trace_event_e      line_event_o,
    output trace_pkg::line_kind_e        line_kind_o,
    output logic [`TRACE_TIME_W-1:0]     line_time_o,
    output logic [`TRACE_XLEN-1:0]       line_pc_o,
    output logic [`TRACE_XLEN-1:0]       line_instr_o,
    output logic [`TRACE_XLEN-1:0]       line_npc_o,
    output logic [`TRACE_REG_AW-1:0]     line_reg_o,
    output logic [`TRACE_XLEN-1:0]       line_value_o,
    output logic                         overflow_o       // Sticky until reset
);
    import trace_pkg::*;

    localparam int REC_W = 2 + `TRACE_TIME_W + 1 + `TRACE_REG_AW + 10 * `TRACE_XLEN;
    localparam int PW    = $clog2(`TRACE_QUEUE_DEPTH);
    localparam int CW    = $clog2(`TRACE_QUEUE_DEPTH + 1);

    // ----------------------------------------------------------
    // Record queue
    // ----------------------------------------------------------
    logic [REC_W-1:0]   q_mem [`TRACE_QUEUE_DEPTH];
    logic [PW-1:0]      wr_ptr, rd_ptr;       // Depth is a power of two, pointers wrap
    logic [CW-1:0]      q_cnt;
    logic [REC_W-1:0]   push_rec;
    logic               full, empty, push, pop;

    // Record currently expanding
    logic [REC_W-1:0]           cur_rec;
    logic [1:0]                 cur_ev_raw;
    trace_event_e               cur_ev;
    logic [`TRACE_TIME_W-1:0]   cur_time;
    logic [`TRACE_XLEN-1:0]     cur_pc, cur_instr, cur_npc, cur_data;
    logic                       cur_reg_wr;
    logic [`TRACE_REG_AW-1:0]   cur_addr;
    logic [`TRACE_XLEN-1:0]     cur_mstatus, cur_mepc, cur_mcause, cur_mtval, cur_mip, cur_mie;

    seq_state_e     state;
    logic [1:0]     line_idx;
    logic [2:0]     n_lines;
    logic           wake_pend;
    logic           advance;
    line_kind_e     kind;

    assign push_rec = {rec_event_i, rec_time_i, rec_pc_i, rec_instr_i, rec_npc_i,
                       rec_reg_wr_i, rec_reg_addr_i, rec_reg_data_i, rec_mstatus_i,
                       rec_mepc_i, rec_mcause_i, rec_mtval_i, rec_mip_i, rec_mie_i};

    assign full  = (q_cnt == CW'(`TRACE_QUEUE_DEPTH));
    assign empty = (q_cnt == '0);
    assign push  = rec_valid_i && !full;    // Dropped when full
    assign advance = (state == SEQ_IDLE) || line_last_o;
    assign pop   = advance && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_cnt      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
            if (rec_valid_i && full) overflow_o <= 1'b1;
        end
    end

    // Storage and head record, no reset
    always_ff @(posedge clk) begin
        if (push) q_mem[wr_ptr] <= push_rec;
        if (pop)  cur_rec <= q_mem[rd_ptr];
    end

    assign {cur_ev_raw, cur_time, cur_pc, cur_instr, cur_npc, cur_reg_wr, cur_addr,
            cur_data, cur_mstatus, cur_mepc, cur_mcause, cur_mtval, cur_mip, cur_mie} = cur_rec;
    assign cur_ev    = trace_event_e'(cur_ev_raw);
    assign wake_pend = |(cur_mip & cur_mie);   // Enabled interrupt pending

    // ----------------------------------------------------------
    // Expansion FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SEQ_IDLE;
        end else if (advance) begin
            state <= empty ? SEQ_IDLE : SEQ_L0;   // Next record back to back
        end else begin
            case (state)
                SEQ_L0:  state <= SEQ_L1;
                SEQ_L1:  state <= SEQ_L2;
                SEQ_L2:  state <= SEQ_L3;
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    always_comb begin
        case (state)
            SEQ_L1:  line_idx = 2'd1;
            SEQ_L2:  line_idx = 2'd2;
            SEQ_L3:  line_idx = 2'd3;
            default: line_idx = 2'd0;
        endcase
        // Lines per record
        if (cur_ev == EV_EXC || cur_ev == EV_IRQ) n_lines = 3'd4;
        else if (cur_ev == EV_WAKE && wake_pend)  n_lines = 3'd2;
        else                                      n_lines = 3'd1;
    end

    // Line kind from event and position
    always_comb begin
        case (cur_ev)
            EV_EXC, EV_IRQ: begin
                case (line_idx)
                    2'd0:    kind = LINE_MSTATUS;
                    2'd1:    kind = LINE_MEPC;
                    2'd2:    kind = LINE_MCAUSE;
                    default: kind = LINE_MTVAL;
                endcase
            end
            EV_WAKE: begin
                if (!wake_pend)          kind = LINE_EMPTY;
                else if (line_idx == 0)  kind = LINE_MIP;
                else                     kind = LINE_MIE;
            end
            default: kind = cur_reg_wr ? LINE_REG : LINE_EMPTY;
        endcase
    end

    // ----------------------------------------------------------
    // Line outputs
    // ----------------------------------------------------------
    assign line_valid_o = (state != SEQ_IDLE);
    assign line_last_o  = line_valid_o && ({1'b0, line_idx} == n_lines - 3'd1);
    assign line_event_o = cur_ev;
    assign line_kind_o  = kind;
    assign line_time_o  = cur_time;
    assign line_pc_o    = cur_pc;
    assign line_instr_o = cur_instr;
    assign line_npc_o   = cur_npc;
    assign line_reg_o   = (kind == LINE_REG) ? cur_addr : '0;

    always_comb begin
        case (kind)
            LINE_REG:     line_value_o = cur_data;
            LINE_MSTATUS: line_value_o = cur_mstatus;
            LINE_MEPC:    line_value_o = cur_mepc;
            LINE_MCAUSE:  line_value_o = cur_mcause;
            LINE_MTVAL:   line_value_o = cur_mtval;
            LINE_MIP:     line_value_o = cur_mip;
            LINE_MIE:     line_value_o = cur_mie;
            default:      line_value_o = '0;   // Empty line
        endcase
    end

endmodule

// File: hw/trace_pkg.sv
// Trace recorder types
// Event classes of a trace record
// Line kinds, which act as the line opcode
// Line sequencer FSM states

package trace_pkg;

    // Event class, priority exc > irq > wake > none
    typedef enum logic [1:0] {
        EV_NONE = 2'd0,
        EV_EXC  = 2'd1,
        EV_IRQ  = 2'd2,
        EV_WAKE = 2'd3
    } trace_event_e;

    // What a single output line reports
    typedef enum logic [2:0] {
        LINE_EMPTY   = 3'd0,    // Nothing to report
        LINE_REG     = 3'd1,    // Register-file write
        LINE_MSTATUS = 3'd2,
        LINE_MEPC    = 3'd3,
        LINE_MCAUSE  = 3'd4,
        LINE_MTVAL   = 3'd5,
        LINE_MIP     = 3'd6,
        LINE_MIE     = 3'd7
    } line_kind_e;

    // Sequencer, one state per line of a record
    typedef enum logic [2:0] {
        SEQ_IDLE = 3'd0,
        SEQ_L0   = 3'd1,
        SEQ_L1   = 3'd2,
        SEQ_L2   = 3'd3,
        SEQ_L3   = 3'd4
    } seq_state_e;

endpackage

// File: hw/trace_recorder.sv
// Trace recorder top level
// CSR image assembly, capture stage and line sequencer

`timescale 1ns/100ps
`include "trace_settings.svh"

module trace_recorder (
    input  logic                         clk,
    input  logic                         rst_n,
    // Retire-side strobes
    input  logic                         pc_update_i,
    input  logic [`TRACE_XLEN-1:0]       next_pc_i,
    input  logic [`TRACE_XLEN-1:0]       instr_i,
    input  logic                         reg_wr_i,
    input  logic [`TRACE_REG_AW-1:0]     reg_addr_i,
    input  logic [`TRACE_XLEN-1:0]       reg_data_i,
    input  logic                         exc_i,
    input  logic                         irq_i,
    input  logic                         wake_i,
    // Loose CSR fields
    input  logic                         mstatus_mie_i,
    input  logic                         mstatus_mpie_i,
    input  logic                         mie_msie_i,
    input  logic                         mie_mtie_i,
    input  logic                         mie_meie_i,
    input  logic                         mip_msip_i,
    input  logic                         mip_mtip_i,
    input  logic                         mip_meip_i,
    input  logic [`TRACE_XLEN-2:0]       mepc_i,
    input  logic                         mcause_irq_i,
    input  logic [`TRACE_EC_W-1:0]       mcause_ec_i,
    input  logic [`TRACE_XLEN-1:0]       mtval_i,
    // Trace lines
    output logic                         line_valid_o,
    output logic                         line_last_o,
    output trace_pkg::trace_event_e      line_event_o,
    output trace_pkg::line_kind_e        line_kind_o,
    output logic [`TRACE_TIME_W-1:0]     line_time_o,
    output logic [`TRACE_XLEN-1:0]       line_pc_o,
    output logic [`TRACE_XLEN-1:0]       line_instr_o,
    output logic [`TRACE_XLEN-1:0]       line_npc_o,
    output logic [`TRACE_REG_AW-1:0]     line_reg_o,
    output logic [`TRACE_XLEN-1:0]       line_value_o,
    output logic                         overflow_o
);
    import trace_pkg::*;

    // CSR images
    logic [`TRACE_XLEN-1:0]     mstatus, mie, mip, mepc, mcause, mtval;

    // Capture to sequencer
    logic                       rec_valid, rec_reg_wr;
    trace_event_e               rec_event;
    logic [`TRACE_TIME_W-1:0]   rec_time;
    logic [`TRACE_XLEN-1:0]     rec_pc, rec_instr, rec_npc, rec_reg_data;
    logic [`TRACE_REG_AW-1:0]   rec_reg_addr;
    logic [`TRACE_XLEN-1:0]     rec_mstatus, rec_mepc, rec_mcause, rec_mtval, rec_mip, rec_mie;

    trace_csr_pack u_csr_pack (
        .mstatus_mie_i, .mstatus_mpie_i,
        .mie_msie_i, .mie_mtie_i, .mie_meie_i,
        .mip_msip_i, .mip_mtip_i, .mip_meip_i,
        .mepc_i, .mcause_irq_i, .mcause_ec_i, .mtval_i,
        .mstatus_o (mstatus), .mie_o (mie), .mip_o (mip),
        .mepc_o (mepc), .mcause_o (mcause), .mtval_o (mtval)
    );

    trace_capture u_capture (
        .clk, .rst_n,
        .pc_update_i, .next_pc_i, .instr_i,
        .reg_wr_i, .reg_addr_i, .reg_data_i,
        .exc_i, .irq_i, .wake_i,
        .mstatus_i (mstatus), .mepc_i (mepc), .mcause_i (mcause),
        .mtval_i (mtval), .mip_i (mip), .mie_i (mie),
        .rec_valid_o (rec_valid), .rec_event_o (rec_event), .rec_time_o (rec_time),
        .rec_pc_o (rec_pc), .rec_instr_o (rec_instr), .rec_npc_o (rec_npc),
        .rec_reg_wr_o (rec_reg_wr), .rec_reg_addr_o (rec_reg_addr),
        .rec_reg_data_o (rec_reg_data),
        .rec_mstatus_o (rec_mstatus), .rec_mepc_o (rec_mepc), .rec_mcause_o (rec_mcause),
        .rec_mtval_o (rec_mtval), .rec_mip_o (rec_mip), .rec_mie_o (rec_mie)
    );

    trace_line_seq u_line_seq (
        .clk, .rst_n,
        .rec_valid_i (rec_valid), .rec_event_i (rec_event), .rec_time_i (rec_time),
        .rec_pc_i (rec_pc), .rec_instr_i (rec_instr), .rec_npc_i (rec_npc),
        .rec_reg_wr_i (rec_reg_wr), .rec_reg_addr_i (rec_reg_addr),
        .rec_reg_data_i (rec_reg_data),
        .rec_mstatus_i (rec_mstatus), .rec_mepc_i (rec_mepc), .rec_mcause_i (rec_mcause),
        .rec_mtval_i (rec_mtval), .rec_mip_i (rec_mip), .rec_mie_i (rec_mie),
        .line_valid_o, .line_last_o, .line_event_o, .line_kind_o, .line_time_o,
        .line_pc_o, .line_instr_o, .line_npc_o, .line_reg_o, .line_value_o,
        .overflow_o
    );

endmodule

// File: hw/trace_settings.svh
// Trace recorder build constants
// Data, register index and time stamp widths
// Record queue depth
// mstatus, mie and mip bit offsets for the machine CSR images

`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// ----------------------------------------------------------
// Widths and depths
// ----------------------------------------------------------
`define TRACE_XLEN          32      // Data and PC width
`define TRACE_REG_AW        5       // Register index width
`define TRACE_EC_W          4       // mcause exception code width
`define TRACE_TIME_W        32      // Cycle time stamp width
`define TRACE_QUEUE_DEPTH   4       // Record queue entries, power of two

// ----------------------------------------------------------
// CSR bit offsets
// ----------------------------------------------------------
`define TRACE_MSTATUS_MIE_BIT   3
`define TRACE_MSTATUS_MPIE_BIT  7
`define TRACE_MSTATUS_MPP_LSB   11
`define TRACE_MPP_MACHINE       2'b11   // Core runs in M-mode only

// Shared by mie and mip
`define TRACE_MSIE_BIT  3
`define TRACE_MTIE_BIT  7
`define TRACE_MEIE_BIT  11

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the trace recorder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module trace_recorder_tb \
    -f verilog.f \
    -o Vtrace_recorder_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtrace_recorder_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0

// File: verilog.f
+incdir+hw
hw/trace_pkg.sv
hw/trace_csr_pack.sv
hw/trace_capture.sv
hw/trace_line_seq.sv
hw/trace_recorder.sv
dv/trace_recorder_chk.sv
dv/trace_recorder_tb.sv
